//--- Bender.yml
package:
  name: dram_ctrl

sources:
  - logic/dram_ctrl_pkg.sv
  - logic/req_if.sv
  - logic/l2_req_buffer.sv
  - logic/bank_page_table.sv
  - logic/refresh_timer.sv
  - logic/dram_fsm.sv
  - logic/read_return.sv
  - logic/dram_ctrl.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/dram_bfm.sv
      - testbench/dram_ctrl_tb.sv

//--- logic/bank_page_table.sv
`default_nettype none

module bank_page_table (
    input  logic                             clk,
    input  logic                             rst,
    input  dram_ctrl_pkg::dram_cmd_e         cmd,
    input  logic [dram_ctrl_pkg::BANK_W-1:0] cmd_bank,
    output logic                             page_hit,
    output logic                             page_empty,
    output logic                             any_open,
    output logic [dram_ctrl_pkg::BANK_W-1:0] dec_bank,
    output logic [dram_ctrl_pkg::ROW_W-1:0]  dec_row,
    output logic [dram_ctrl_pkg::COL_W-1:0]  dec_col,
    req_if.decode                            head
);
    import dram_ctrl_pkg::*;

    logic [NUM_BANKS-1:0] row_valid;
    logic [ROW_W-1:0]     open_row [NUM_BANKS];

    // address split
    assign dec_row  = head.head_addr[ROW_LSB +: ROW_W];
    assign dec_bank = head.head_addr[BANK_LSB +: BANK_W];
    assign dec_col  = head.head_addr[COL_LSB +: COL_W];

    assign page_empty = !row_valid[dec_bank];
    assign page_hit   = row_valid[dec_bank] && (open_row[dec_bank] == dec_row);
    assign any_open   = |row_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_valid <= '0;
        end else begin
            case (cmd)
                ACT:     row_valid[cmd_bank] <= 1'b1;
                PRE:     row_valid[cmd_bank] <= 1'b0;
                PREA:    row_valid <= '0;
                default: row_valid <= row_valid;
            endcase
        end
    end

    // head is still unpopped during ACT, so its row is the one opened
    always_ff @(posedge clk) begin
        if (cmd == ACT) begin
            open_row[cmd_bank] <= dec_row;
        end
    end

    a_no_act_to_open_bank: assert property (@(posedge clk) disable iff (rst)
        cmd == ACT |-> !row_valid[cmd_bank]);

endmodule

`default_nettype wire

//--- logic/dram_ctrl.sv
`default_nettype none

module dram_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    // L2 request side
    input  logic                             req_valid,
    input  logic                             req_write,
    input  logic [dram_ctrl_pkg::ADDR_W-1:0] req_addr,
    input  logic [dram_ctrl_pkg::DATA_W-1:0] req_wdata,
    output logic                             req_credit,
    // L2 response side
    output logic                             rsp_valid,
    output logic [dram_ctrl_pkg::DATA_W-1:0] rsp_rdata,
    // DRAM command and data
    output dram_ctrl_pkg::dram_cmd_e         cmd,
    output logic [dram_ctrl_pkg::BANK_W-1:0] cmd_bank,
    output logic [dram_ctrl_pkg::ROW_W-1:0]  cmd_row,
    output logic [dram_ctrl_pkg::COL_W-1:0]  cmd_col,
    output logic [dram_ctrl_pkg::DATA_W-1:0] dram_wdata,
    input  logic [dram_ctrl_pkg::DATA_W-1:0] dram_rdata
);
    import dram_ctrl_pkg::*;

    logic              page_hit;
    logic              page_empty;
    logic              any_open;
    logic [BANK_W-1:0] dec_bank;
    logic [ROW_W-1:0]  dec_row;
    logic [COL_W-1:0]  dec_col;
    logic              refresh_req;
    logic              refresh_start;
    logic              rd_issue;

    req_if head_if ();

    l2_req_buffer u_req_buffer (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .head       (head_if.buffer)
    );

    bank_page_table u_page_table (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_bank   (cmd_bank),
        .page_hit   (page_hit),
        .page_empty (page_empty),
        .any_open   (any_open),
        .dec_bank   (dec_bank),
        .dec_row    (dec_row),
        .dec_col    (dec_col),
        .head       (head_if.decode)
    );

    refresh_timer u_refresh_timer (
        .clk           (clk),
        .rst           (rst),
        .refresh_start (refresh_start),
        .refresh_req   (refresh_req)
    );

    dram_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .page_hit      (page_hit),
        .page_empty    (page_empty),
        .any_open      (any_open),
        .dec_bank      (dec_bank),
        .dec_row       (dec_row),
        .dec_col       (dec_col),
        .refresh_req   (refresh_req),
        .refresh_start (refresh_start),
        .rd_issue      (rd_issue),
        .cmd           (cmd),
        .cmd_bank      (cmd_bank),
        .cmd_row       (cmd_row),
        .cmd_col       (cmd_col),
        .dram_wdata    (dram_wdata),
        .head          (head_if.sched)
    );

    read_return u_read_return (
        .clk        (clk),
        .rst        (rst),
        .rd_issue   (rd_issue),
        .dram_rdata (dram_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

endmodule

`default_nettype wire

//--- logic/dram_ctrl_pkg.sv
`default_nettype none

package dram_ctrl_pkg;

    // address fields, row on top, then bank, then column
    localparam int BANK_W = 3;
    localparam int ROW_W  = 7;
    localparam int COL_W  = 3;
    localparam int ADDR_W = ROW_W + BANK_W + COL_W;
    localparam int DATA_W = 8;

    localparam int COL_LSB  = 0;
    localparam int BANK_LSB = COL_W;
    localparam int ROW_LSB  = COL_W + BANK_W;

    localparam int NUM_BANKS = 1 << BANK_W;

    // request buffer, depth equals the initial credit count
    localparam int REQ_DEPTH = 8;
    localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);

    // DRAM timing in controller cycles
    localparam int T_RCD            = 2;
    localparam int T_RP             = 2;
    localparam int T_RFC            = 8;
    localparam int CAS_LAT          = 3;
    localparam int REFRESH_INTERVAL = 200;

    localparam int WAIT_W    = $clog2(T_RFC);
    localparam int REF_CNT_W = $clog2(REFRESH_INTERVAL);

    typedef enum logic [2:0] {
        NOP  = 3'd0,
        ACT  = 3'd1,
        RD   = 3'd2,
        WR   = 3'd3,
        PRE  = 3'd4,
        PREA = 3'd5,
        REF  = 3'd6
    } dram_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        PRECHARGE,
        ACTIVATE,
        ACCESS,
        REFRESH_PRE,
        REFRESH,
        WAIT
    } fsm_state_e;

endpackage

`default_nettype wire

//--- logic/dram_fsm.sv
`default_nettype none

module dram_fsm (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             page_hit,
    input  logic                             page_empty,
    input  logic                             any_open,
    input  logic [dram_ctrl_pkg::BANK_W-1:0] dec_bank,
    input  logic [dram_ctrl_pkg::ROW_W-1:0]  dec_row,
    input  logic [dram_ctrl_pkg::COL_W-1:0]  dec_col,
    input  logic                             refresh_req,
    output logic                             refresh_start,
    output logic                             rd_issue,
    output dram_ctrl_pkg::dram_cmd_e         cmd,
    output logic [dram_ctrl_pkg::BANK_W-1:0] cmd_bank,
    output logic [dram_ctrl_pkg::ROW_W-1:0]  cmd_row,
    output logic [dram_ctrl_pkg::COL_W-1:0]  cmd_col,
    output logic [dram_ctrl_pkg::DATA_W-1:0] dram_wdata,
    req_if.sched                             head
);
    import dram_ctrl_pkg::*;

    fsm_state_e        state;
    fsm_state_e        state_n;
    fsm_state_e        ret_state;
    fsm_state_e        ret_state_n;
    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] wait_cnt_n;
    dram_cmd_e         cmd_n;
    dram_cmd_e         access_cmd;
    logic              pop_q;
    logic              pop_n;
    logic              head_new;

    // head still waiting for its column command
    assign head_new   = head.head_valid && !pop_q;
    assign access_cmd = head.head_write ? WR : RD;

    assign refresh_start = (state == REFRESH);
    assign head.pop      = pop_q;

    // every command is registered, so a wait of n cycles
    // spends n-1 cycles in WAIT before the next command is set up
    always_comb begin
        state_n     = state;
        ret_state_n = ret_state;
        wait_cnt_n  = wait_cnt;
        cmd_n       = NOP;
        pop_n       = 1'b0;
        case (state)
            IDLE: begin
                // refresh wins between requests
                if (refresh_req) begin
                    state_n = any_open ? REFRESH_PRE : REFRESH;
                end else if (head_new) begin
                    if (page_hit) begin
                        cmd_n = access_cmd;
                        pop_n = 1'b1;
                    end else if (page_empty) begin
                        state_n = ACTIVATE;
                    end else begin
                        state_n = PRECHARGE;
                    end
                end
            end
            PRECHARGE: begin
                cmd_n       = PRE;
                state_n     = WAIT;
                wait_cnt_n  = WAIT_W'(T_RP - 2);
                ret_state_n = ACTIVATE;
            end
            ACTIVATE: begin
                cmd_n       = ACT;
                state_n     = WAIT;
                wait_cnt_n  = WAIT_W'(T_RCD - 2);
                ret_state_n = ACCESS;
            end
            ACCESS: begin
                cmd_n   = access_cmd;
                pop_n   = 1'b1;
                state_n = IDLE;
            end
            REFRESH_PRE: begin
                cmd_n       = PREA;
                state_n     = WAIT;
                wait_cnt_n  = WAIT_W'(T_RP - 2);
                ret_state_n = REFRESH;
            end
            REFRESH: begin
                cmd_n       = REF;
                state_n     = WAIT;
                wait_cnt_n  = WAIT_W'(T_RFC - 2);
                ret_state_n = IDLE;
            end
            WAIT: begin
                if (wait_cnt == '0) begin
                    state_n = ret_state;
                end else begin
                    wait_cnt_n = wait_cnt - 1'b1;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            ret_state <= IDLE;
            wait_cnt  <= '0;
            cmd       <= NOP;
            pop_q     <= 1'b0;
            rd_issue  <= 1'b0;
        end else begin
            state     <= state_n;
            ret_state <= ret_state_n;
            wait_cnt  <= wait_cnt_n;
            cmd       <= cmd_n;
            pop_q     <= pop_n;
            rd_issue  <= (cmd_n == RD);
        end
    end

    // command address and write data, valid alongside cmd
    always_ff @(posedge clk) begin
        if (cmd_n != NOP) begin
            cmd_bank <= dec_bank;
            cmd_row  <= dec_row;
            cmd_col  <= dec_col;
        end
        if (cmd_n == WR) begin
            dram_wdata <= head.head_wdata;
        end
    end

    // column access always lands on the row the table holds open
    a_access_on_open_row: assert property (@(posedge clk) disable iff (rst)
        (cmd == RD || cmd == WR) |-> page_hit && (dec_bank == cmd_bank));

endmodule

`default_nettype wire

//--- logic/l2_req_buffer.sv
`default_nettype none

module l2_req_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid,
    input  logic                             req_write,
    input  logic [dram_ctrl_pkg::ADDR_W-1:0] req_addr,
    input  logic [dram_ctrl_pkg::DATA_W-1:0] req_wdata,
    output logic                             req_credit,
    req_if.buffer                            head
);
    import dram_ctrl_pkg::*;

    logic              write_mem [REQ_DEPTH];
    logic [ADDR_W-1:0] addr_mem  [REQ_DEPTH];
    logic [DATA_W-1:0] data_mem  [REQ_DEPTH];

    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_CNT_W-1:0] count;
    logic                 full;

    assign full = (count == REQ_CNT_W'(REQ_DEPTH));

    // storage, written on every accepted request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            write_mem[wr_ptr] <= req_write;
            addr_mem[wr_ptr]  <= req_addr;
            data_mem[wr_ptr]  <= req_wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, head.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head.head_valid = (count != '0);
    assign head.head_write = write_mem[rd_ptr];
    assign head.head_addr  = addr_mem[rd_ptr];
    assign head.head_wdata = data_mem[rd_ptr];

    // one credit back per popped entry
    assign req_credit = head.pop;

    // requester must hold a credit before sending
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !full);

    // scheduler only consumes a present head
    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        head.pop |-> count != '0);

endmodule

`default_nettype wire

//--- logic/read_return.sv
`default_nettype none

module read_return (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rd_issue,
    input  logic [dram_ctrl_pkg::DATA_W-1:0] dram_rdata,
    output logic                             rsp_valid,
    output logic [dram_ctrl_pkg::DATA_W-1:0] rsp_rdata
);
    import dram_ctrl_pkg::*;

    // one bit per cycle of CAS latency, several reads may be in flight
    logic [CAS_LAT-1:0] inflight;
    logic               capture;

    // oldest bit set means dram_rdata is valid now
    assign capture = inflight[CAS_LAT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            inflight  <= {inflight[CAS_LAT-2:0], rd_issue};
            rsp_valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rsp_rdata <= dram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/refresh_timer.sv
`default_nettype none

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_start,
    output logic refresh_req
);
    import dram_ctrl_pkg::*;

    logic [REF_CNT_W-1:0] interval_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            interval_cnt <= '0;
            refresh_req  <= 1'b0;
        end else if (refresh_start) begin
            // restart the interval at each refresh
            interval_cnt <= '0;
            refresh_req  <= 1'b0;
        end else if (!refresh_req) begin
            if (interval_cnt == REF_CNT_W'(REFRESH_INTERVAL - 1)) begin
                refresh_req <= 1'b1;
            end else begin
                interval_cnt <= interval_cnt + 1'b1;
            end
        end
    end

    // scheduler starts a refresh only when one is pending
    a_start_only_when_pending: assert property (@(posedge clk) disable iff (rst)
        refresh_start |-> refresh_req);

endmodule

`default_nettype wire

//--- logic/req_if.sv
`default_nettype none

interface req_if;
    import dram_ctrl_pkg::*;

    // oldest request held in the buffer
    logic              head_valid;
    logic              head_write;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    // head consumed this cycle
    logic              pop;

    modport buffer (
        output head_valid, head_write, head_addr, head_wdata,
        input  pop
    );

    modport sched (
        input  head_valid, head_write, head_addr, head_wdata,
        output pop
    );

    modport decode (input head_addr);

endinterface

`default_nettype wire

//--- testbench/dram_bfm.sv
`default_nettype none

module dram_bfm (
    input  logic                             clk,
    input  logic                             rst,
    input  dram_ctrl_pkg::dram_cmd_e         cmd,
    input  logic [dram_ctrl_pkg::BANK_W-1:0] cmd_bank,
    input  logic [dram_ctrl_pkg::ROW_W-1:0]  cmd_row,
    input  logic [dram_ctrl_pkg::COL_W-1:0]  cmd_col,
    input  logic [dram_ctrl_pkg::DATA_W-1:0] dram_wdata,
    output logic [dram_ctrl_pkg::DATA_W-1:0] dram_rdata,
    output int                               error_count
);
    import dram_ctrl_pkg::*;

    // longest legal distance between two REF commands
    localparam int REF_GAP_MAX = REFRESH_INTERVAL + T_RP + T_RCD + T_RFC + 4;
    localparam int LONG_AGO    = -1000;

    logic [DATA_W-1:0]    mem [1 << ADDR_W];
    logic [DATA_W-1:0]    rd_pipe [CAS_LAT];
    logic [NUM_BANKS-1:0] bank_open;
    logic [ROW_W-1:0]     open_row [NUM_BANKS];
    int                   last_act [NUM_BANKS];
    int                   last_pre [NUM_BANKS];
    int                   last_prea;
    int                   last_ref;
    int                   cycle;
    bit                   ref_late;

    // power-on content, a function of every address bit
    function automatic logic [DATA_W-1:0] power_on_byte(input int addr);
        return DATA_W'(addr ^ (addr >> 5) ^ 'h5a);
    endfunction

    task automatic report_violation(input string what);
        error_count++;
        $display("DRAM error at cycle %0d: %s", cycle, what);
    endtask

    initial begin
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = power_on_byte(a);
        end
        for (int i = 0; i < CAS_LAT; i++) begin
            rd_pipe[i] = '0;
        end
        dram_rdata = '0;
        cycle      = 0;
    end

    // commands are sampled mid-cycle, where they are stable
    always @(negedge clk) begin : model
        logic [ADDR_W-1:0] addr;
        int                newest_pre;
        // data of the RD issued CAS_LAT cycles ago
        dram_rdata = rd_pipe[CAS_LAT-1];
        for (int i = CAS_LAT - 1; i > 0; i--) begin
            rd_pipe[i] = rd_pipe[i-1];
        end
        rd_pipe[0] = '0;
        addr = {open_row[cmd_bank], cmd_bank, cmd_col};
        if (rst) begin
            bank_open   = '0;
            last_prea   = LONG_AGO;
            last_ref    = cycle;
            ref_late    = 1'b0;
            error_count = 0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                last_act[b] = LONG_AGO;
                last_pre[b] = LONG_AGO;
            end
        end else begin
            if (cmd != NOP && cycle - last_ref < T_RFC) begin
                report_violation("command issued before tRFC elapsed");
            end
            case (cmd)
                ACT: begin
                    if (bank_open[cmd_bank]) begin
                        report_violation("ACT to a bank that is already open");
                    end
                    if (cycle - last_pre[cmd_bank] < T_RP || cycle - last_prea < T_RP) begin
                        report_violation("ACT issued before tRP elapsed");
                    end
                    bank_open[cmd_bank] = 1'b1;
                    open_row[cmd_bank]  = cmd_row;
                    last_act[cmd_bank]  = cycle;
                end
                RD, WR: begin
                    if (!bank_open[cmd_bank]) begin
                        report_violation("RD or WR to a closed bank");
                    end else if (cycle - last_act[cmd_bank] < T_RCD) begin
                        report_violation("RD or WR issued before tRCD elapsed");
                    end
                    if (cmd == WR) begin
                        mem[addr] = dram_wdata;
                    end else begin
                        rd_pipe[0] = mem[addr];
                    end
                end
                PRE: begin
                    bank_open[cmd_bank] = 1'b0;
                    last_pre[cmd_bank]  = cycle;
                end
                PREA: begin
                    bank_open = '0;
                    last_prea = cycle;
                end
                REF: begin
                    if (|bank_open) begin
                        report_violation("REF while a bank is open");
                    end
                    newest_pre = last_prea;
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        if (last_pre[b] > newest_pre) begin
                            newest_pre = last_pre[b];
                        end
                    end
                    if (cycle - newest_pre < T_RP) begin
                        report_violation("REF issued before tRP elapsed");
                    end
                    last_ref = cycle;
                    ref_late = 1'b0;
                end
                default: begin
                end
            endcase
            if (!ref_late && cycle - last_ref > REF_GAP_MAX) begin
                ref_late = 1'b1;
                report_violation("refresh overdue, gap between REF commands too long");
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- testbench/dram_ctrl_tb.sv
`default_nettype none

module dram_ctrl_tb;
    import dram_ctrl_pkg::*;

    localparam int NUM_REQS   = 300;
    localparam int MAX_GAP    = 3;
    // few rows, so row hits and read-after-write both occur
    localparam int ROWS_USED  = 4;
    localparam int IDLE_CHECK = 10;
    localparam int TAIL       = CAS_LAT + 16;
    localparam int BASE_CYCLES    = NUM_REQS * (T_RP + T_RCD + 4);
    localparam int REF_ALLOWANCE  = (BASE_CYCLES / REFRESH_INTERVAL + 1) * (T_RP + T_RFC + 4);
    localparam int TIMEOUT_CYCLES = BASE_CYCLES + REF_ALLOWANCE + IDLE_CHECK + TAIL + 100;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              req_credit;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_rdata;
    dram_cmd_e         cmd;
    logic [BANK_W-1:0] cmd_bank;
    logic [ROW_W-1:0]  cmd_row;
    logic [COL_W-1:0]  cmd_col;
    logic [DATA_W-1:0] dram_wdata;
    logic [DATA_W-1:0] dram_rdata;

    logic [DATA_W-1:0] model_mem [1 << ADDR_W];
    logic [DATA_W-1:0] exp_q [$];
    int                credits;
    int                sent;
    int                reads_sent;
    int                rsp_count;
    int                error_count;
    int                bfm_errors;
    int                cycle_count;

    tb_clock_gen #(.PERIOD(10)) u_clk (.clk(clk));

    dram_ctrl uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .cmd        (cmd),
        .cmd_bank   (cmd_bank),
        .cmd_row    (cmd_row),
        .cmd_col    (cmd_col),
        .dram_wdata (dram_wdata),
        .dram_rdata (dram_rdata)
    );

    dram_bfm u_bfm (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_bank    (cmd_bank),
        .cmd_row     (cmd_row),
        .cmd_col     (cmd_col),
        .dram_wdata  (dram_wdata),
        .dram_rdata  (dram_rdata),
        .error_count (bfm_errors)
    );

    // DRAM content at power-on, covers the whole address
    function automatic logic [DATA_W-1:0] power_on_byte(input int addr);
        return DATA_W'(addr ^ (addr >> 5) ^ 'h5a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic collect_outputs(output bit credit_seen);
        if (rsp_valid) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("response arrived with no read outstanding");
            end else begin
                check_value("rsp_rdata", exp_q.pop_front(), rsp_rdata);
            end
        end
        credit_seen = req_credit;
    endtask

    // a returned credit is spent from the next cycle on
    task automatic take_back_credit(input bit credit_seen);
        if (credit_seen) begin
            credits++;
        end
        if (credits > REQ_DEPTH) begin
            error_count++;
            $display("credit counter rose above the buffer depth of %0d", REQ_DEPTH);
        end
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
    endtask

    task automatic send_random_request();
        int                row;
        int                bank;
        int                col;
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] data;
        row   = $urandom_range(0, ROWS_USED - 1);
        bank  = $urandom_range(0, (1 << BANK_W) - 1);
        col   = $urandom_range(0, (1 << COL_W) - 1);
        addr  = {ROW_W'(row), BANK_W'(bank), COL_W'(col)};
        write = 1'($urandom_range(0, 1));
        data  = DATA_W'($urandom);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        // no reordering, so the model can resolve each read when it is sent
        if (write) begin
            model_mem[addr] = data;
        end else begin
            exp_q.push_back(model_mem[addr]);
            reads_sent++;
        end
        credits--;
        sent++;
    endtask

    task automatic finish_run(input bit timed_out);
        $display("errors: %0d in checks, %0d DRAM protocol", error_count, bfm_errors);
        if (error_count == 0 && bfm_errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run(1'b1);
    end

    initial begin
        bit credit_seen;
        int gap;
        void'($urandom(97518));
        rst         = 1'b1;
        cycle_count = 0;
        credits     = REQ_DEPTH;
        sent        = 0;
        reads_sent  = 0;
        rsp_count   = 0;
        error_count = 0;
        gap         = 0;
        drive_idle();
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            model_mem[a] = power_on_byte(a);
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // quiet outputs before the first request, first refresh comes much later
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            check_value("cmd", NOP, cmd);
            check_value("req_credit", 0, req_credit);
            check_value("rsp_valid", 0, rsp_valid);
        end

        while (sent < NUM_REQS) begin
            @(negedge clk);
            collect_outputs(credit_seen);
            if (gap > 0) begin
                gap--;
                drive_idle();
            end else if (credits > 0) begin
                send_random_request();
                gap = $urandom_range(0, MAX_GAP);
            end else begin
                drive_idle();
            end
            take_back_credit(credit_seen);
        end

        // drain, then watch for stray responses or credits
        while (credits < REQ_DEPTH || exp_q.size() != 0) begin
            @(negedge clk);
            collect_outputs(credit_seen);
            drive_idle();
            take_back_credit(credit_seen);
        end
        repeat (TAIL) begin
            @(negedge clk);
            collect_outputs(credit_seen);
            take_back_credit(credit_seen);
        end

        check_value("rsp_count", reads_sent, rsp_count);
        check_value("credits", REQ_DEPTH, credits);
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- verilog.f
logic/dram_ctrl_pkg.sv
logic/req_if.sv
logic/l2_req_buffer.sv
logic/bank_page_table.sv
logic/refresh_timer.sv
logic/dram_fsm.sv
logic/read_return.sv
logic/dram_ctrl.sv
testbench/tb_clock_gen.sv
testbench/dram_bfm.sv
testbench/dram_ctrl_tb.sv
